/* dac_subsystem.f */
+incdir+hdl
hdl/dac_pkg.sv
hdl/dac_lane_if.sv
hdl/dac_regs.sv
hdl/lfsr_lane.sv
hdl/tri_wave_gen.sv
hdl/batch_assembler.sv
hdl/dac_subsystem.sv
verif/dac_properties.sv
verif/dac_checker.sv
verif/dac_subsystem_tb.sv

/* hdl/batch_assembler.sv */
`include "dac_params.svh"

module batch_assembler (
	input  logic               halt,
	input  dac_pkg::dac_mode_t mode,
	input  logic               dac_rdy,
	dac_lane_if.drain          lanes,
	input  dac_pkg::batch_t    tri_batch,
	output logic              tri_run,
	output dac_pkg::batch_t    dac_batch,
	output logic               dac_valid
);
	import dac_pkg::*;

	logic rand_sel;
	logic tri_sel;
	batch_t lane_batch;

	// mode 3 falls through as off
	assign rand_sel = (mode == MODE_RAND);
	assign tri_sel = (mode == MODE_TRI);

	assign dac_valid = dac_rdy && !halt && (rand_sel || tri_sel);

	// step only the source whose batch is taken
	assign lanes.run = dac_valid && rand_sel;
	assign tri_run = dac_valid && tri_sel;

	always_comb begin
		lane_batch = '0;
		for (int i = 0; i < `DAC_LANES; i++)
			lane_batch[i*`DAC_SAMPLE_WIDTH +: `DAC_SAMPLE_WIDTH] = lanes.samples[i];
	end

	always_comb begin
		dac_batch = '0;
		if (dac_valid) begin
			if (rand_sel)
				dac_batch = lane_batch;
			else
				dac_batch = tri_batch;
		end
	end

endmodule

/* hdl/dac_lane_if.sv */
`include "dac_params.svh"

interface dac_lane_if;
	import dac_pkg::*;

	// per lane seed, held by the register block
	sample_t seeds [`DAC_LANES];
	// one cycle seed load
	logic load;
	// step every lane once
	logic run;
	// current lane outputs
	sample_t samples [`DAC_LANES];

	modport regs (
		output seeds,
		output load
	);

	modport lane (
		input  seeds,
		input  load,
		input  run,
		output samples
	);

	modport drain (
		output run,
		input  samples
	);

endinterface

/* hdl/dac_params.svh */
`ifndef DAC_PARAMS_SVH
`define DAC_PARAMS_SVH

// sample and batch geometry
`define DAC_SAMPLE_WIDTH 16
`define DAC_LANES 4

// wishbone word address and data
`define DAC_WB_ADDR_WIDTH 3
`define DAC_WB_DATA_WIDTH 32

// register map, seeds for lanes 0 to 3 follow the base
`define DAC_REG_CTRL 0
`define DAC_REG_SEED_BASE 1

// triangle wave
`define DAC_TRI_STEP 16'h1000
`define DAC_TRI_PEAK 16'hF000

// galois feedback mask
`define DAC_LFSR_TAPS 16'hB400

`endif

/* hdl/dac_pkg.sv */
`include "dac_params.svh"

package dac_pkg;

	// one dac sample
	typedef logic [`DAC_SAMPLE_WIDTH-1:0] sample_t;

	// lane 0 in the low bits
	typedef logic [`DAC_LANES*`DAC_SAMPLE_WIDTH-1:0] batch_t;

	typedef logic [`DAC_WB_ADDR_WIDTH-1:0] wb_addr_t;
	typedef logic [`DAC_WB_DATA_WIDTH-1:0] wb_data_t;

	// control bits 1:0, value 3 behaves as off
	typedef enum logic [1:0] {
		MODE_OFF  = 2'd0,
		MODE_RAND = 2'd1,
		MODE_TRI  = 2'd2
	} dac_mode_t;

endpackage

/* hdl/dac_regs.sv */
`include "dac_params.svh"

module dac_regs (
	input  logic               clk,
	input  logic               rst,
	input  logic               wb_cyc,
	input  logic               wb_stb,
	input  logic               wb_we,
	input  dac_pkg::wb_addr_t  wb_adr,
	input  dac_pkg::wb_data_t  wb_dat_i,
	output dac_pkg::wb_data_t  wb_dat_o,
	output logic               wb_ack,
	output dac_pkg::dac_mode_t mode,
	output logic               halt,
	output logic               tri_restart,
	dac_lane_if.regs           lanes
);
	import dac_pkg::*;

	logic [1:0] mode_bits;
	logic access;
	logic ctrl_wr;
	logic wr_pend;
	logic load_pend;
	logic restart_pend;
	logic apply_mode;
	wb_data_t rd_data;

	// first cycle of cyc and stb, ack not yet given
	assign access = wb_cyc && wb_stb && !wb_ack;
	assign ctrl_wr = access && wb_we && (wb_adr == wb_addr_t'(`DAC_REG_CTRL));

	always_comb begin
		rd_data = '0;
		if (wb_adr == wb_addr_t'(`DAC_REG_CTRL)) begin
			rd_data[1:0] = mode_bits;
			rd_data[2] = halt;
		end
		for (int i = 0; i < `DAC_LANES; i++) begin
			if (wb_adr == wb_addr_t'(`DAC_REG_SEED_BASE + i))
				rd_data[`DAC_SAMPLE_WIDTH-1:0] = lanes.seeds[i];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_ack <= 1'b0;
			mode_bits <= 2'd0;
			halt <= 1'b0;
			for (int i = 0; i < `DAC_LANES; i++)
				lanes.seeds[i] <= '0;
		end else begin
			wb_ack <= access;
			if (ctrl_wr) begin
				mode_bits <= wb_dat_i[1:0];
				halt <= wb_dat_i[2];
			end
			for (int i = 0; i < `DAC_LANES; i++) begin
				if (access && wb_we && (wb_adr == wb_addr_t'(`DAC_REG_SEED_BASE + i)))
					lanes.seeds[i] <= wb_dat_i[`DAC_SAMPLE_WIDTH-1:0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (access && !wb_we)
			wb_dat_o <= rd_data;
	end

	// control write side effects, one cycle behind ack
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_pend <= 1'b0;
			load_pend <= 1'b0;
			restart_pend <= 1'b0;
			apply_mode <= 1'b0;
			lanes.load <= 1'b0;
			tri_restart <= 1'b0;
			mode <= MODE_OFF;
		end else begin
			wr_pend <= ctrl_wr;
			load_pend <= ctrl_wr && (wb_dat_i[1:0] == MODE_RAND);
			restart_pend <= ctrl_wr && (wb_dat_i[1:0] != mode_bits);
			apply_mode <= wr_pend;
			lanes.load <= load_pend;
			tri_restart <= restart_pend;
			// new mode lands with the seed load and triangle restart
			if (apply_mode)
				mode <= dac_mode_t'(mode_bits);
		end
	end

endmodule

/* hdl/dac_subsystem.sv */
`include "dac_params.svh"

module dac_subsystem (
	input  logic              clk,
	input  logic              rst,
	input  logic              wb_cyc,
	input  logic              wb_stb,
	input  logic              wb_we,
	input  dac_pkg::wb_addr_t wb_adr,
	input  dac_pkg::wb_data_t wb_dat_i,
	output dac_pkg::wb_data_t wb_dat_o,
	output logic              wb_ack,
	input  logic              dac_rdy,
	output dac_pkg::batch_t   dac_batch,
	output logic              dac_valid
);
	import dac_pkg::*;

	dac_mode_t mode;
	logic halt;
	logic tri_restart;
	logic tri_run;
	batch_t tri_batch;

	dac_lane_if lanes ();

	dac_regs u_regs (
		.clk         (clk),
		.rst         (rst),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_i    (wb_dat_i),
		.wb_dat_o    (wb_dat_o),
		.wb_ack      (wb_ack),
		.mode        (mode),
		.halt        (halt),
		.tri_restart (tri_restart),
		.lanes       (lanes)
	);

	// noise source, one lfsr per sample slot
	for (genvar i = 0; i < `DAC_LANES; i++) begin : g_lane
		lfsr_lane #(
			.lane_index (i)
		) u_lane (
			.clk  (clk),
			.rst  (rst),
			.lane (lanes)
		);
	end

	tri_wave_gen u_tri (
		.clk     (clk),
		.rst     (rst),
		.restart (tri_restart),
		.run     (tri_run),
		.batch   (tri_batch)
	);

	batch_assembler u_asm (
		.halt      (halt),
		.mode      (mode),
		.dac_rdy   (dac_rdy),
		.lanes     (lanes),
		.tri_batch (tri_batch),
		.tri_run   (tri_run),
		.dac_batch (dac_batch),
		.dac_valid (dac_valid)
	);

endmodule

/* hdl/lfsr_lane.sv */
`include "dac_params.svh"

module lfsr_lane #(
	parameter int lane_index = 0
) (
	input logic     clk,
	input logic     rst,
	dac_lane_if.lane lane
);
	import dac_pkg::*;

	sample_t state;
	sample_t next_state;

	// galois step, feedback from the bit shifted out
	always_comb begin
		next_state = {1'b0, state[`DAC_SAMPLE_WIDTH-1:1]};
		if (state[0])
			next_state = next_state ^ `DAC_LFSR_TAPS;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= sample_t'(1);
		end else if (lane.load) begin
			// all zero would lock up
			if (lane.seeds[lane_index] == '0)
				state <= sample_t'(1);
			else
				state <= lane.seeds[lane_index];
		end else if (lane.run) begin
			state <= next_state;
		end
	end

	assign lane.samples[lane_index] = state;

endmodule

/* hdl/tri_wave_gen.sv */
`include "dac_params.svh"

module tri_wave_gen (
	input  logic            clk,
	input  logic            rst,
	input  logic            restart,
	input  logic            run,
	output dac_pkg::batch_t batch
);
	import dac_pkg::*;

	sample_t value;
	logic rising;
	sample_t next_value;
	logic next_rising;

	// one triangle step, returns {rising, value}
	function automatic logic [`DAC_SAMPLE_WIDTH:0] tri_step(input logic up, input sample_t v);
		logic [`DAC_SAMPLE_WIDTH:0] r;
		if (up) begin
			if (v == `DAC_TRI_PEAK)
				r = {1'b0, sample_t'(v - `DAC_TRI_STEP)};
			else
				r = {1'b1, sample_t'(v + `DAC_TRI_STEP)};
		end else begin
			if (v == '0)
				r = {1'b1, sample_t'(v + `DAC_TRI_STEP)};
			else
				r = {1'b0, sample_t'(v - `DAC_TRI_STEP)};
		end
		return r;
	endfunction

	// four consecutive samples from the current point
	always_comb begin
		sample_t v;
		logic up;
		v = value;
		up = rising;
		batch = '0;
		for (int i = 0; i < `DAC_LANES; i++) begin
			batch[i*`DAC_SAMPLE_WIDTH +: `DAC_SAMPLE_WIDTH] = v;
			{up, v} = tri_step(up, v);
		end
		next_value = v;
		next_rising = up;
	end

	always_ff @(posedge clk) begin
		if (rst || restart) begin
			value <= '0;
			rising <= 1'b1;
		end else if (run) begin
			value <= next_value;
			rising <= next_rising;
		end
	end

endmodule

/* verif/dac_checker.sv */
`include "dac_params.svh"

module dac_checker (
	input  logic              clk,
	input  logic              rst,
	input  logic              wb_cyc,
	input  logic              wb_stb,
	input  logic              wb_we,
	input  dac_pkg::wb_addr_t wb_adr,
	input  dac_pkg::wb_data_t wb_dat_i,
	input  dac_pkg::wb_data_t wb_dat_o,
	input  logic              wb_ack,
	input  dac_pkg::wb_data_t rd_expect,
	input  logic              dac_rdy,
	input  dac_pkg::batch_t   dac_batch,
	input  logic              dac_valid,
	output int                errors,
	output int                batches
);
	import dac_pkg::*;

	localparam int W = `DAC_SAMPLE_WIDTH;
	// triangle cycle: half steps up, half steps down
	localparam int HALF = `DAC_TRI_PEAK / `DAC_TRI_STEP;
	localparam int PERIOD = 2 * HALF;

	sample_t seed [`DAC_LANES];
	sample_t lfsr [`DAC_LANES];
	logic [1:0] mode;
	logic halt;
	int tri_pos;

	function automatic sample_t tri_sample(input int pos);
		int p;
		p = pos % PERIOD;
		if (p <= HALF)
			return sample_t'(p * `DAC_TRI_STEP);
		return sample_t'((PERIOD - p) * `DAC_TRI_STEP);
	endfunction

	function automatic sample_t galois(input sample_t s);
		if (s[0])
			return (s >> 1) ^ `DAC_LFSR_TAPS;
		return s >> 1;
	endfunction

	function automatic batch_t model_batch();
		batch_t b;
		b = '0;
		for (int i = 0; i < `DAC_LANES; i++) begin
			if (mode == MODE_RAND)
				b[i*W +: W] = lfsr[i];
			else
				b[i*W +: W] = tri_sample(tri_pos + i);
		end
		return b;
	endfunction

	always @(posedge clk) begin
		logic exp_valid;
		batch_t exp_batch;
		int fails;
		int idx;
		fails = 0;
		if (rst) begin
			mode = 2'd0;
			halt = 1'b0;
			tri_pos = 0;
			for (int i = 0; i < `DAC_LANES; i++) begin
				seed[i] = '0;
				lfsr[i] = sample_t'(1);
			end
			errors <= 0;
			batches <= 0;
		end else begin
			exp_valid = dac_rdy && !halt && (mode == MODE_RAND || mode == MODE_TRI);
			exp_batch = exp_valid ? model_batch() : '0;
			if (dac_valid !== exp_valid) begin
				$display("CHECK FAILED dac_valid expected %h got %h", exp_valid, dac_valid);
				fails++;
			end else if (dac_batch !== exp_batch) begin
				$display("CHECK FAILED dac_batch expected %h got %h", exp_batch, dac_batch);
				fails++;
			end
			// accepted batch steps the active model
			if (exp_valid && dac_valid) begin
				if (mode == MODE_RAND) begin
					for (int i = 0; i < `DAC_LANES; i++)
						lfsr[i] = galois(lfsr[i]);
				end else begin
					tri_pos = (tri_pos + `DAC_LANES) % PERIOD;
				end
				batches <= batches + 1;
			end
			if (wb_ack && !wb_we && wb_dat_o !== rd_expect) begin
				$display("CHECK FAILED wb_dat_o at address %0d expected %h got %h",
					wb_adr, rd_expect, wb_dat_o);
				fails++;
			end
			// write lands on this edge
			if (wb_cyc && wb_stb && wb_we && !wb_ack) begin
				idx = int'(wb_adr) - `DAC_REG_SEED_BASE;
				if (wb_adr == wb_addr_t'(`DAC_REG_CTRL)) begin
					if (wb_dat_i[1:0] != mode)
						tri_pos = 0;
					if (wb_dat_i[1:0] == MODE_RAND) begin
						for (int i = 0; i < `DAC_LANES; i++)
							lfsr[i] = (seed[i] == '0) ? sample_t'(1) : seed[i];
					end
					mode = wb_dat_i[1:0];
					halt = wb_dat_i[2];
				end else if (idx >= 0 && idx < `DAC_LANES) begin
					seed[idx] = wb_dat_i[W-1:0];
				end
			end
			errors <= errors + fails;
		end
	end

endmodule

/* verif/dac_properties.sv */
module dac_properties (
	input logic            clk,
	input logic            rst,
	input logic            wb_cyc,
	input logic            wb_stb,
	input logic            wb_ack,
	input logic            dac_rdy,
	input logic            dac_valid,
	input dac_pkg::batch_t dac_batch
);
	int fail_count = 0;

	// single cycle ack, only for a live request
	ack_pulse: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
		else begin
			$error("wb_ack stayed high for more than one cycle");
			fail_count++;
		end

	ack_request: assert property (@(posedge clk) disable iff (rst)
		wb_ack |-> $past(wb_cyc && wb_stb))
		else begin
			$error("wb_ack raised without a request");
			fail_count++;
		end

	valid_needs_rdy: assert property (@(posedge clk) disable iff (rst) dac_valid |-> dac_rdy)
		else begin
			$error("dac_valid high while dac_rdy low");
			fail_count++;
		end

	idle_batch_zero: assert property (@(posedge clk) disable iff (rst)
		!dac_valid |-> (dac_batch == '0))
		else begin
			$error("dac_batch not zero while dac_valid low");
			fail_count++;
		end

endmodule

bind dac_subsystem dac_properties props (
	.clk       (clk),
	.rst       (rst),
	.wb_cyc    (wb_cyc),
	.wb_stb    (wb_stb),
	.wb_ack    (wb_ack),
	.dac_rdy   (dac_rdy),
	.dac_valid (dac_valid),
	.dac_batch (dac_batch)
);

/* verif/dac_subsystem_tb.sv */
`include "dac_params.svh"

module dac_subsystem_tb;
	import dac_pkg::*;

	typedef enum {OP_WR, OP_RD, OP_STREAM, OP_IDLE} op_t;
	typedef enum {RDY_HIGH, RDY_RAND} rdy_t;
	typedef struct {
		op_t op;
		int adr;
		wb_data_t data;
		int count;
		rdy_t rdy;
	} row_t;

	logic clk;
	logic rst;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	wb_addr_t wb_adr;
	wb_data_t wb_dat_i;
	wb_data_t wb_dat_o;
	logic wb_ack;
	logic dac_rdy;
	batch_t dac_batch;
	logic dac_valid;
	wb_data_t rd_expect;
	int errors;
	int batches;
	int timeouts;
	int unsigned rnd;

	// data column holds the write value or the expected read value
	row_t stim [38] = '{
		'{OP_RD, 0, 32'h0000_0000, 0, RDY_HIGH}, '{OP_WR, 1, 32'h1234_ACE1, 0, RDY_HIGH},
		'{OP_WR, 2, 32'h0000_0000, 0, RDY_HIGH}, '{OP_WR, 3, 32'hFFFF_8001, 0, RDY_HIGH},
		'{OP_WR, 4, 32'h0000_0F0F, 0, RDY_HIGH}, '{OP_RD, 1, 32'h0000_ACE1, 0, RDY_HIGH},
		'{OP_RD, 2, 32'h0000_0000, 0, RDY_HIGH}, '{OP_RD, 3, 32'h0000_8001, 0, RDY_HIGH},
		'{OP_RD, 4, 32'h0000_0F0F, 0, RDY_HIGH}, '{OP_RD, 5, 32'h0000_0000, 0, RDY_HIGH},
		'{OP_RD, 7, 32'h0000_0000, 0, RDY_HIGH}, '{OP_WR, 0, 32'h0000_0003, 0, RDY_HIGH},
		'{OP_RD, 0, 32'h0000_0003, 0, RDY_HIGH}, '{OP_IDLE, 0, 32'h0, 10, RDY_HIGH},
		'{OP_WR, 0, 32'h0000_0001, 0, RDY_HIGH}, '{OP_STREAM, 0, 32'h0, 6, RDY_HIGH},
		'{OP_STREAM, 0, 32'h0, 20, RDY_RAND}, '{OP_WR, 1, 32'h0000_BEEF, 0, RDY_HIGH},
		'{OP_STREAM, 0, 32'h0, 3, RDY_HIGH}, '{OP_WR, 0, 32'h0000_0002, 0, RDY_HIGH},
		'{OP_STREAM, 0, 32'h0, 12, RDY_HIGH}, '{OP_STREAM, 0, 32'h0, 10, RDY_RAND},
		'{OP_WR, 0, 32'h0000_0006, 0, RDY_HIGH}, '{OP_RD, 0, 32'h0000_0006, 0, RDY_HIGH},
		'{OP_IDLE, 0, 32'h0, 12, RDY_HIGH}, '{OP_WR, 0, 32'h0000_0002, 0, RDY_HIGH},
		'{OP_STREAM, 0, 32'h0, 5, RDY_HIGH}, '{OP_WR, 0, 32'h0000_0001, 0, RDY_HIGH},
		'{OP_STREAM, 0, 32'h0, 4, RDY_HIGH}, '{OP_WR, 0, 32'h0000_0002, 0, RDY_HIGH},
		'{OP_STREAM, 0, 32'h0, 3, RDY_HIGH}, '{OP_WR, 0, 32'h0000_0000, 0, RDY_HIGH},
		'{OP_IDLE, 0, 32'h0, 8, RDY_HIGH}, '{OP_RD, 0, 32'h0000_0000, 0, RDY_HIGH},
		'{OP_WR, 0, 32'h0000_0005, 0, RDY_HIGH}, '{OP_IDLE, 0, 32'h0, 8, RDY_HIGH},
		'{OP_WR, 0, 32'h0000_0001, 0, RDY_HIGH}, '{OP_STREAM, 0, 32'h0, 3, RDY_RAND}
	};

	dac_subsystem uut (
		.clk       (clk),
		.rst       (rst),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_i  (wb_dat_i),
		.wb_dat_o  (wb_dat_o),
		.wb_ack    (wb_ack),
		.dac_rdy   (dac_rdy),
		.dac_batch (dac_batch),
		.dac_valid (dac_valid)
	);

	dac_checker chk (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// one classic cycle then two idle clocks for the delayed control effects
	task automatic bus_access(input logic we, input int adr, input wb_data_t data);
		int cycles;
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= we;
		wb_adr <= wb_addr_t'(adr);
		wb_dat_i <= we ? data : '0;
		rd_expect <= data;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
		end while (!wb_ack && cycles < 20);
		if (!wb_ack) begin
			$display("timeout: no wb_ack for access at address %0d", adr);
			timeouts++;
		end
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
		repeat (2) @(posedge clk);
	endtask

	task automatic collect_batches(input int count, input rdy_t rdy);
		int target;
		int cycles;
		target = batches + count;
		cycles = 0;
		while (batches < target && cycles < count * 20 + 50) begin
			rnd = $urandom;
			dac_rdy <= (rdy == RDY_RAND) ? rnd[0] : 1'b1;
			@(posedge clk);
			cycles++;
		end
		if (batches < target) begin
			$display("timeout: only %0d of %0d batches accepted", count - (target - batches),
				count);
			timeouts++;
		end
		dac_rdy <= 1'b0;
		@(posedge clk);
	endtask

	// ready held high while no batch may be offered
	task automatic hold_ready(input int count);
		repeat (count) begin
			dac_rdy <= 1'b1;
			@(posedge clk);
		end
		dac_rdy <= 1'b0;
		@(posedge clk);
	endtask

	initial begin
		rnd = $urandom(32'h1a50_407b);
		timeouts = 0;
		rst = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_i = '0;
		dac_rdy = 1'b0;
		rd_expect = '0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		foreach (stim[i]) begin
			case (stim[i].op)
				OP_WR: bus_access(1'b1, stim[i].adr, stim[i].data);
				OP_RD: bus_access(1'b0, stim[i].adr, stim[i].data);
				OP_STREAM: collect_batches(stim[i].count, stim[i].rdy);
				default: hold_ready(stim[i].count);
			endcase
		end
		repeat (2) @(posedge clk);
		$display("batches %0d, check errors %0d, assertion failures %0d, timeouts %0d",
			batches, errors, uut.props.fail_count, timeouts);
		if (errors == 0 && uut.props.fail_count == 0 && timeouts == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule
